//--- verilog.f
hdl/wqm_pkg.sv
hdl/sq_doorbell_fifo.sv
hdl/wqe_fetch.sv
hdl/sq_sequencer.sv
hdl/sq_segmenter.sv
hdl/wq_manager.sv
dv/wq_manager_chk.sv
dv/wq_manager_tb.sv

//--- dv/wq_manager_tb.sv
`timescale 1ns/1ps

module wq_manager_tb import wqm_pkg::*; ();

  localparam int CLK_NS      = 40;
  localparam int WQE_MAX_CYC = 80;  // one wqe, worst delays and stalls
  localparam int N_WQE       = 8;
  localparam int TEST_CYC    = N_WQE * WQE_MAX_CYC + 40 + 5;

  logic                  axis_aclk_i, axis_rstn_i;
  logic                  sq_updated_i;
  sq_db_t                sq_db_i;
  logic [ADDR_W-1:0]     ar_addr_o;
  logic                  ar_valid_o, ar_ready_i;
  logic [AXI_DATA_W-1:0] r_data_i;
  logic                  r_last_i, r_valid_i, r_ready_o;
  sq_req_t               sq_req_o;
  logic                  sq_req_valid_o, sq_req_ready_i;
  logic                  ack_valid_i, ack_ready_o;
  cq_head_t              cq_head_o;
  logic                  cq_head_valid_o;

  wqe_t              mem_wqe [logic [ADDR_W-1:0]];
  sq_req_t           got_reqs[$], exp_reqs[$];
  cq_head_t          got_heads[$], exp_heads[$];
  logic [ADDR_W-1:0] got_addrs[$], exp_addrs[$];
  integer            seed = 17129;
  logic              rand_mode;
  logic              rd_open = 1'b0;
  string             cur_test = "reset";
  int                ack_wait = 0;
  int                errors, tests;

  wq_manager uut (.*);

  always #(CLK_NS / 2) axis_aclk_i = ~axis_aclk_i;

  ////////////////////
  // axi memory model
  ////////////////////

  initial begin : axi_mem
    logic [ADDR_W-1:0] addr;
    int                gap;
    forever begin
      @(posedge axis_aclk_i);
      if (ar_valid_o) begin
        addr = ar_addr_o;
        gap  = rand_mode ? $unsigned($random(seed)) % 4 : 2;
        repeat (gap) @(posedge axis_aclk_i);
        ar_ready_i <= 1'b1;
        @(posedge axis_aclk_i);
        ar_ready_i <= 1'b0;
        gap = rand_mode ? $unsigned($random(seed)) % 4 : 1;
        repeat (gap) @(posedge axis_aclk_i);
        r_valid_i <= 1'b1;
        r_last_i  <= 1'b1;
        r_data_i  <= mem_wqe.exists(addr) ? mem_wqe[addr] : {8{addr}};  // fill by address
        do @(posedge axis_aclk_i); while (!r_ready_o);
        r_valid_i <= 1'b0;
        r_last_i  <= 1'b0;
      end
    end
  end

  // request ready, ack responder, result capture
  always @(posedge axis_aclk_i) begin
    sq_req_ready_i <= rand_mode ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
    if (ar_valid_o && ar_ready_i) got_addrs.push_back(ar_addr_o);
    if (ack_wait == 1) ack_valid_i <= 1'b1;
    if (ack_wait != 0) ack_wait <= ack_wait - 1;
    if (sq_req_valid_o && sq_req_ready_i) begin
      got_reqs.push_back(sq_req_o);
      if (sq_req_o.last) ack_wait <= 3;  // ack a few cycles later
    end
    if (ack_valid_i && ack_ready_o) ack_valid_i <= 1'b0;
    if (cq_head_valid_o) got_heads.push_back(cq_head_o);
    // r_ready only while a read is open
    if (ar_valid_o && ar_ready_i) rd_open <= 1'b1;
    if (r_valid_i && r_ready_o && r_last_i) rd_open <= 1'b0;
    check_flag(cur_test, "r_ready", rd_open, r_ready_o);
    check_flag(cur_test, "ack_ready", ack_valid_i, ack_ready_o);
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic wqe_t make_wqe(wqe_op_e op, logic [LEN_W-1:0] len,
                                    logic [ADDR_W-1:0] la, logic [ADDR_W-1:0] rv);
    wqe_t w;
    w              = '0;
    w.opcode       = op;
    w.length       = len;
    w.local_addr   = la;
    w.remote_vaddr = rv;
    w.wr_id        = 16'h5a3c;
    return w;
  endfunction

  task automatic ring_doorbell(logic [QPN_W-1:0] qp, int head, int prod,
                               logic [ADDR_W-1:0] base);
    @(posedge axis_aclk_i);
    sq_updated_i <= 1'b1;
    sq_db_i      <= '{qp_idx: qp, sq_prod_idx: prod, cq_head_idx: head, sq_base_addr: base};
    @(posedge axis_aclk_i);
    sq_updated_i <= 1'b0;
  endtask

  task automatic expect_req(rc_op_e op, logic [QPN_W-1:0] qp, logic last,
                            logic [ADDR_W-1:0] rv, logic [ADDR_W-1:0] la,
                            logic [LEN_W-1:0] len);
    exp_reqs.push_back('{opcode: op, qpn: qp, last: last, remote_vaddr: rv,
                         local_addr: la, len: len});
  endtask

  task automatic expect_wqe(logic [QPN_W-1:0] qp, logic [ADDR_W-1:0] addr, int head_after);
    exp_addrs.push_back(addr);
    exp_heads.push_back('{qp_idx: qp, head_idx: head_after});
  endtask

  task automatic start_test(string name);
    tests++;
    cur_test = name;
    got_reqs.delete();
    exp_reqs.delete();
    got_heads.delete();
    exp_heads.delete();
    got_addrs.delete();
    exp_addrs.delete();
    $display("running %s", name);
  endtask

  task automatic wait_heads(string name, int n);
    int cyc;
    cyc = 0;
    while (got_heads.size() < n && cyc < n * WQE_MAX_CYC) begin
      @(posedge axis_aclk_i);
      cyc++;
    end
    if (got_heads.size() < n) begin
      errors++;
      $display("%s: no head write-back after %0d cycles", name, cyc);
    end
    repeat (4) @(posedge axis_aclk_i);
  endtask

  task automatic check_req(string name, sq_req_t exp, sq_req_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: request expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_head(string name, cq_head_t exp, cq_head_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: head expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, logic [ADDR_W-1:0] exp, logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: fetch address expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, string sig, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: %s expected %b, actual %b", name, sig, exp, act);
    end
  endtask

  task automatic compare_all(string name);
    if (got_reqs.size() != exp_reqs.size()) begin
      errors++;
      $display("Fail %s: expected %0d requests, actual %0d", name, exp_reqs.size(),
               got_reqs.size());
    end else foreach (exp_reqs[i]) check_req(name, exp_reqs[i], got_reqs[i]);
    if (got_heads.size() != exp_heads.size()) begin
      errors++;
      $display("Fail %s: expected %0d write-backs, actual %0d", name, exp_heads.size(),
               got_heads.size());
    end else foreach (exp_heads[i]) check_head(name, exp_heads[i], got_heads[i]);
    if (got_addrs.size() != exp_addrs.size()) begin
      errors++;
      $display("Fail %s: expected %0d fetches, actual %0d", name, exp_addrs.size(),
               got_addrs.size());
    end else foreach (exp_addrs[i]) check_addr(name, exp_addrs[i], got_addrs[i]);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_write_only();
    logic [ADDR_W-1:0] base = 64'h0000_1000_0000_0000;
    logic [ADDR_W-1:0] la   = 64'h0000_0000_2000_0000;
    logic [ADDR_W-1:0] rv   = 64'h0000_7f00_0000_1000;
    start_test("write only");
    mem_wqe[base + 4 * 64] = make_wqe(WQE_WRITE, 1000, la, rv);
    expect_req(RC_WRITE_ONLY, 8'd3, 1'b1, rv, la, 1000);
    expect_wqe(8'd3, base + 4 * 64, 5);
    ring_doorbell(8'd3, 4, 5, base);
    wait_heads("write only", 1);
    compare_all("write only");
  endtask

  task automatic test_write_multi(string name);
    logic [ADDR_W-1:0] base = 64'h0000_2000_0000_0000;
    logic [ADDR_W-1:0] la   = 64'h0000_0000_3000_0000;
    logic [ADDR_W-1:0] rv   = 64'h0000_7f00_0010_0000;
    start_test(name);
    mem_wqe[base] = make_wqe(WQE_WRITE, 9000, la, rv);
    expect_req(RC_WRITE_FIRST, 8'd7, 1'b0, rv, la, 4096);
    expect_req(RC_WRITE_MIDDLE, 8'd7, 1'b0, rv + 4096, la + 4096, 4096);
    expect_req(RC_WRITE_LAST, 8'd7, 1'b1, rv + 8192, la + 8192, 808);
    expect_wqe(8'd7, base, 1);
    ring_doorbell(8'd7, 0, 1, base);
    wait_heads(name, 1);
    compare_all(name);
  endtask

  task automatic test_send_multi(string name);
    logic [ADDR_W-1:0] base = 64'h0000_3000_0000_0000;
    logic [ADDR_W-1:0] la   = 64'h0000_0000_4000_0000;
    start_test(name);
    mem_wqe[base + 128] = make_wqe(WQE_SEND, 5000, la, 64'hdead_beef_0000_0000);
    expect_req(RC_SEND_FIRST, 8'd9, 1'b0, '0, la, 4096);
    expect_req(RC_SEND_LAST, 8'd9, 1'b1, '0, la + 4096, 904);
    expect_wqe(8'd9, base + 128, 3);
    ring_doorbell(8'd9, 2, 3, base);
    wait_heads(name, 1);
    compare_all(name);
  endtask

  task automatic test_read();
    logic [ADDR_W-1:0] base = 64'h0000_4000_0000_0000;
    logic [ADDR_W-1:0] la   = 64'h0000_0000_5000_0000;
    logic [ADDR_W-1:0] rv   = 64'h0000_7f00_0200_0000;
    start_test("read");
    mem_wqe[base] = make_wqe(WQE_READ, 20000, la, rv);
    expect_req(RC_READ_REQUEST, 8'd1, 1'b1, rv, la, 20000);
    expect_wqe(8'd1, base, 1);
    ring_doorbell(8'd1, 0, 1, base);
    wait_heads("read", 1);
    compare_all("read");
  endtask

  // head 1, producer 3, so two wqes in ring order
  task automatic test_multi_wqe();
    logic [ADDR_W-1:0] base = 64'h0000_5000_0000_0000;
    logic [ADDR_W-1:0] la   = 64'h0000_0000_6000_0000;
    logic [ADDR_W-1:0] rv   = 64'h0000_7f00_0300_0000;
    start_test("two wqes");
    mem_wqe[base + 64]  = make_wqe(WQE_WRITE, 100, la, rv);
    mem_wqe[base + 128] = make_wqe(WQE_SEND, 200, la + 100, rv);
    expect_req(RC_WRITE_ONLY, 8'd5, 1'b1, rv, la, 100);
    expect_req(RC_SEND_ONLY, 8'd5, 1'b1, '0, la + 100, 200);
    expect_wqe(8'd5, base + 64, 2);
    expect_wqe(8'd5, base + 128, 3);
    ring_doorbell(8'd5, 1, 3, base);
    wait_heads("two wqes", 2);
    compare_all("two wqes");
  endtask

  task automatic test_empty_doorbell();
    start_test("empty doorbell");
    ring_doorbell(8'd6, 3, 3, 64'h0000_6000_0000_0000);
    repeat (20) @(posedge axis_aclk_i);
    ring_doorbell(8'd6, 5, 2, 64'h0000_6000_0000_0000);
    repeat (20) @(posedge axis_aclk_i);
    compare_all("empty doorbell");
  endtask

  task automatic test_backpressure();
    rand_mode = 1'b1;
    test_write_multi("write under back-pressure");
    test_send_multi("send under back-pressure");
    rand_mode = 1'b0;
  endtask

  initial begin
    axis_aclk_i    = 1'b0;
    axis_rstn_i    = 1'b1;
    sq_updated_i   = 1'b0;
    sq_db_i        = '0;
    ar_ready_i     = 1'b0;
    r_data_i       = '0;
    r_last_i       = 1'b0;
    r_valid_i      = 1'b0;
    sq_req_ready_i = 1'b0;
    ack_valid_i    = 1'b0;
    rand_mode      = 1'b0;
    errors         = 0;
    tests          = 0;
    axis_rstn_i <= 1'b0;
    repeat (5) @(posedge axis_aclk_i);
    axis_rstn_i <= 1'b1;
    repeat (2) @(posedge axis_aclk_i);
    test_write_only();
    test_write_multi("write three segments");
    test_send_multi("send two segments");
    test_read();
    test_multi_wqe();
    test_empty_doorbell();
    test_backpressure();
    errors = errors + uut.u_chk.assert_fails;
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TEST_CYC * CLK_NS * 3 / 2);
    $display("watchdog expired before the tests finished, %0d errors so far", errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- dv/wq_manager_chk.sv
`timescale 1ns/1ps

module wq_manager_chk import wqm_pkg::*; (
  input logic    axis_aclk_i,
  input logic    axis_rstn_i,
  input logic    ar_valid_i,
  input logic    ar_ready_i,
  input logic    r_ready_i,
  input sq_req_t sq_req_i,
  input logic    sq_req_valid_i,
  input logic    sq_req_ready_i,
  input logic    ack_ready_i,
  input logic    cq_head_valid_i
);

  int assert_fails = 0;

  ar_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i)
    else begin
      assert_fails++;
      $error("ar_valid dropped before ar_ready");
    end

  // request must not change while stalled
  req_hold: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    sq_req_valid_i && !sq_req_ready_i |=> sq_req_valid_i && $stable(sq_req_i))
    else begin
      assert_fails++;
      $error("request dropped or changed before ready");
    end

  head_pulse: assert property (@(posedge axis_aclk_i) disable iff (!axis_rstn_i)
    cq_head_valid_i |=> !cq_head_valid_i)
    else begin
      assert_fails++;
      $error("head write-back longer than one cycle");
    end

  reset_quiet: assert property (@(posedge axis_aclk_i)
    !axis_rstn_i |-> !(ar_valid_i || r_ready_i || sq_req_valid_i || ack_ready_i
                       || cq_head_valid_i))
    else begin
      assert_fails++;
      $error("control output high during reset");
    end

endmodule

bind wq_manager wq_manager_chk u_chk (
  .axis_aclk_i     (axis_aclk_i),
  .axis_rstn_i     (axis_rstn_i),
  .ar_valid_i      (ar_valid_o),
  .ar_ready_i      (ar_ready_i),
  .r_ready_i       (r_ready_o),
  .sq_req_i        (sq_req_o),
  .sq_req_valid_i  (sq_req_valid_o),
  .sq_req_ready_i  (sq_req_ready_i),
  .ack_ready_i     (ack_ready_o),
  .cq_head_valid_i (cq_head_valid_o)
);

//--- hdl/wq_manager.sv
`timescale 1ns/1ps

module wq_manager import wqm_pkg::*; (
  input  logic                  axis_aclk_i,
  input  logic                  axis_rstn_i,
  input  logic                  sq_updated_i,
  input  sq_db_t                sq_db_i,
  output logic [ADDR_W-1:0]     ar_addr_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  input  logic [AXI_DATA_W-1:0] r_data_i,
  input  logic                  r_last_i,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  output sq_req_t               sq_req_o,
  output logic                  sq_req_valid_o,
  input  logic                  sq_req_ready_i,
  input  logic                  ack_valid_i,
  output logic                  ack_ready_o,
  output cq_head_t              cq_head_o,
  output logic                  cq_head_valid_o
);

  logic              db_valid, db_pop;
  sq_db_t            db_data;
  logic              fetch_start, wqe_valid;
  logic [ADDR_W-1:0] fetch_addr;
  wqe_t              wqe;
  logic              seg_start, seg_done;

  sq_doorbell_fifo u_db_fifo (
    .axis_aclk_i  (axis_aclk_i),
    .axis_rstn_i  (axis_rstn_i),
    .sq_updated_i (sq_updated_i),
    .sq_db_i      (sq_db_i),
    .db_pop_i     (db_pop),
    .db_valid_o   (db_valid),
    .db_data_o    (db_data)
  );

  wqe_fetch u_fetch (
    .axis_aclk_i   (axis_aclk_i),
    .axis_rstn_i   (axis_rstn_i),
    .fetch_start_i (fetch_start),
    .fetch_addr_i  (fetch_addr),
    .ar_addr_o     (ar_addr_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .r_data_i      (r_data_i),
    .r_last_i      (r_last_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .wqe_valid_o   (wqe_valid),
    .wqe_o         (wqe)
  );

  sq_sequencer u_seq (
    .axis_aclk_i     (axis_aclk_i),
    .axis_rstn_i     (axis_rstn_i),
    .db_valid_i      (db_valid),
    .db_data_i       (db_data),
    .db_pop_o        (db_pop),
    .fetch_start_o   (fetch_start),
    .fetch_addr_o    (fetch_addr),
    .wqe_valid_i     (wqe_valid),
    .seg_start_o     (seg_start),
    .seg_done_i      (seg_done),
    .ack_valid_i     (ack_valid_i),
    .ack_ready_o     (ack_ready_o),
    .cq_head_o       (cq_head_o),
    .cq_head_valid_o (cq_head_valid_o)
  );

  // qp index rides along with the head value
  sq_segmenter u_seg (
    .axis_aclk_i    (axis_aclk_i),
    .axis_rstn_i    (axis_rstn_i),
    .seg_start_i    (seg_start),
    .wqe_i          (wqe),
    .qp_idx_i       (cq_head_o.qp_idx),
    .sq_req_o       (sq_req_o),
    .sq_req_valid_o (sq_req_valid_o),
    .sq_req_ready_i (sq_req_ready_i),
    .seg_done_o     (seg_done)
  );

endmodule

//--- hdl/sq_segmenter.sv
`timescale 1ns/1ps

module sq_segmenter import wqm_pkg::*; (
  input  logic             axis_aclk_i,
  input  logic             axis_rstn_i,
  input  logic             seg_start_i,
  input  wqe_t             wqe_i,
  input  logic [QPN_W-1:0] qp_idx_i,
  output sq_req_t          sq_req_o,
  output logic             sq_req_valid_o,
  input  logic             sq_req_ready_i,
  output logic             seg_done_o
);

  localparam logic [LEN_W-1:0] MTU = LEN_W'(MTU_BYTES);

  logic              busy_q;
  logic              first_q;
  wqe_op_e           op_q;
  logic [QPN_W-1:0]  qpn_q;
  logic [LEN_W-1:0]  rem_len_q;
  logic [ADDR_W-1:0] loc_q, rmt_q;
  logic              fits;
  logic              hs;

  assign fits = (rem_len_q <= MTU);
  assign hs   = busy_q && sq_req_ready_i;

  ////////////////////
  // segment state
  ////////////////////

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      busy_q  <= 1'b0;
      first_q <= 1'b0;
    end else if (seg_start_i) begin
      busy_q  <= 1'b1;
      first_q <= 1'b1;
    end else if (hs) begin
      first_q <= 1'b0;
      if (sq_req_o.last) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (seg_start_i) begin
      op_q      <= wqe_i.opcode;
      qpn_q     <= qp_idx_i;
      rem_len_q <= wqe_i.length;
      loc_q     <= wqe_i.local_addr;
      rmt_q     <= wqe_i.remote_vaddr;
    end else if (hs) begin
      rem_len_q <= rem_len_q - MTU;
      loc_q     <= loc_q + ADDR_W'(MTU_BYTES);
      rmt_q     <= rmt_q + ADDR_W'(MTU_BYTES);
    end
  end

  ////////////////////
  // request decode
  ////////////////////

  always_comb begin
    sq_req_o.qpn          = qpn_q;
    sq_req_o.local_addr   = loc_q;
    sq_req_o.remote_vaddr = rmt_q;
    sq_req_o.last         = fits;
    sq_req_o.len          = fits ? rem_len_q : MTU;
    case (op_q)
      WQE_WRITE: begin
        if (first_q) sq_req_o.opcode = fits ? RC_WRITE_ONLY : RC_WRITE_FIRST;
        else         sq_req_o.opcode = fits ? RC_WRITE_LAST : RC_WRITE_MIDDLE;
      end
      WQE_SEND: begin
        if (first_q) sq_req_o.opcode = fits ? RC_SEND_ONLY : RC_SEND_FIRST;
        else         sq_req_o.opcode = fits ? RC_SEND_LAST : RC_SEND_MIDDLE;
        sq_req_o.remote_vaddr = '0;  // no remote address on send
      end
      default: begin
        // read goes out whole in one request
        sq_req_o.opcode = RC_READ_REQUEST;
        sq_req_o.last   = 1'b1;
        sq_req_o.len    = rem_len_q;
      end
    endcase
  end

  assign sq_req_valid_o = busy_q;
  assign seg_done_o     = hs && sq_req_o.last;

endmodule

//--- hdl/sq_sequencer.sv
`timescale 1ns/1ps

module sq_sequencer import wqm_pkg::*; (
  input  logic              axis_aclk_i,
  input  logic              axis_rstn_i,
  input  logic              db_valid_i,
  input  sq_db_t            db_data_i,
  output logic              db_pop_o,
  output logic              fetch_start_o,
  output logic [ADDR_W-1:0] fetch_addr_o,
  input  logic              wqe_valid_i,
  output logic              seg_start_o,
  input  logic              seg_done_i,
  input  logic              ack_valid_i,
  output logic              ack_ready_o,
  output cq_head_t          cq_head_o,
  output logic              cq_head_valid_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_WAIT_WQE,
    ST_WAIT_SEG,
    ST_WAIT_ACK,
    ST_HEAD_UPD,
    ST_FINISH
  } state_e;

  state_e           state_q;
  sq_db_t           db_q;
  logic [IDX_W-1:0] idx_q;
  logic             more_wqe;
  logic             start_first;

  assign more_wqe    = (idx_q < db_q.sq_prod_idx);
  assign start_first = (state_q == ST_CHECK) && (db_q.sq_prod_idx > db_q.cq_head_idx);

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q     <= ST_IDLE;
      idx_q       <= '0;
      seg_start_o <= 1'b0;
    end else begin
      seg_start_o <= (state_q == ST_WAIT_WQE) && wqe_valid_i;
      case (state_q)
        ST_IDLE: begin
          if (db_valid_i) begin
            idx_q   <= db_data_i.cq_head_idx;  // walk starts at the head
            state_q <= ST_CHECK;
          end
        end
        ST_CHECK:    state_q <= start_first ? ST_WAIT_WQE : ST_IDLE;
        ST_WAIT_WQE: if (wqe_valid_i) state_q <= ST_WAIT_SEG;
        ST_WAIT_SEG: if (seg_done_i) state_q <= ST_WAIT_ACK;
        ST_WAIT_ACK: begin
          if (ack_valid_i) begin
            idx_q   <= idx_q + 1'b1;
            state_q <= ST_HEAD_UPD;
          end
        end
        ST_HEAD_UPD: state_q <= ST_FINISH;
        default:     state_q <= more_wqe ? ST_WAIT_WQE : ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (db_pop_o) db_q <= db_data_i;
  end

  ////////////////////
  // outputs
  ////////////////////

  assign db_pop_o        = (state_q == ST_IDLE) && db_valid_i;
  assign fetch_start_o   = start_first || ((state_q == ST_FINISH) && more_wqe);
  assign fetch_addr_o    = db_q.sq_base_addr + ADDR_W'(idx_q) * ADDR_W'(WQE_BYTES);
  assign ack_ready_o     = (state_q == ST_WAIT_ACK) && ack_valid_i;
  assign cq_head_valid_o = (state_q == ST_HEAD_UPD);
  assign cq_head_o       = '{qp_idx: db_q.qp_idx, head_idx: idx_q};

endmodule

//--- hdl/wqe_fetch.sv
`timescale 1ns/1ps

module wqe_fetch import wqm_pkg::*; (
  input  logic                  axis_aclk_i,
  input  logic                  axis_rstn_i,
  input  logic                  fetch_start_i,
  input  logic [ADDR_W-1:0]     fetch_addr_i,
  output logic [ADDR_W-1:0]     ar_addr_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  input  logic [AXI_DATA_W-1:0] r_data_i,
  input  logic                  r_last_i,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  output logic                  wqe_valid_o,
  output wqe_t                  wqe_o
);

  typedef enum logic [1:0] {AR_IDLE, AR_VALID, AR_DONE} ar_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_BEATS, RD_DONE} rd_state_e;

  ar_state_e ar_state_q;
  rd_state_e rd_state_q;

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      ar_state_q <= AR_IDLE;
      rd_state_q <= RD_IDLE;
    end else begin
      case (ar_state_q)
        AR_IDLE:  if (fetch_start_i) ar_state_q <= AR_VALID;
        AR_VALID: if (ar_ready_i) ar_state_q <= AR_DONE;
        default:  if (rd_state_q == RD_DONE) ar_state_q <= AR_IDLE;  // wait for data
      endcase
      case (rd_state_q)
        RD_IDLE:  if (ar_valid_o && ar_ready_i) rd_state_q <= RD_BEATS;
        RD_BEATS: if (r_valid_i && r_last_i) rd_state_q <= RD_DONE;
        default:  rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // address and beat data, no reset needed
  always_ff @(posedge axis_aclk_i) begin
    if (ar_state_q == AR_IDLE && fetch_start_i) ar_addr_o <= fetch_addr_i;
    if (r_ready_o && r_valid_i) wqe_o <= r_data_i;  // last beat wins
  end

  assign ar_valid_o  = (ar_state_q == AR_VALID);
  assign r_ready_o   = (rd_state_q == RD_BEATS);
  assign wqe_valid_o = (rd_state_q == RD_DONE);

endmodule

//--- hdl/sq_doorbell_fifo.sv
`timescale 1ns/1ps

module sq_doorbell_fifo import wqm_pkg::*; (
  input  logic   axis_aclk_i,
  input  logic   axis_rstn_i,
  input  logic   sq_updated_i,
  input  sq_db_t sq_db_i,
  input  logic   db_pop_i,
  output logic   db_valid_o,
  output sq_db_t db_data_o
);

  sq_db_t              cap_q;
  logic                cap_vld_q;
  sq_db_t              mem [DB_FIFO_DEPTH];
  logic [DB_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [DB_CNT_W-1:0] count_q;
  logic                push, pop;

  assign push = cap_vld_q && (count_q != DB_CNT_W'(DB_FIFO_DEPTH));  // full drops it
  assign pop  = db_pop_i && (count_q != '0);

  // capture stage
  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      cap_vld_q <= 1'b0;
    end else begin
      cap_vld_q <= sq_updated_i;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (sq_updated_i) cap_q <= sq_db_i;
    if (push) mem[wr_ptr_q] <= cap_q;
  end

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign db_valid_o = (count_q != '0);
  assign db_data_o  = mem[rd_ptr_q];

endmodule

//--- hdl/wqm_pkg.sv
package wqm_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int MTU_BYTES     = 4096;
  localparam int WQE_BYTES     = 64;   // ring stride
  localparam int AXI_DATA_W    = 512;
  localparam int ADDR_W        = 64;
  localparam int IDX_W         = 32;
  localparam int LEN_W         = 32;
  localparam int QPN_W         = 8;
  localparam int DB_FIFO_DEPTH = 8;
  localparam int DB_PTR_W      = $clog2(DB_FIFO_DEPTH);
  localparam int DB_CNT_W      = $clog2(DB_FIFO_DEPTH + 1);

  ////////////////////
  // opcodes
  ////////////////////

  typedef enum logic [7:0] {
    WQE_WRITE = 8'h00,
    WQE_SEND  = 8'h02,
    WQE_READ  = 8'h04
  } wqe_op_e;

  // ib rc transport opcodes
  typedef enum logic [7:0] {
    RC_SEND_FIRST   = 8'h00,
    RC_SEND_MIDDLE  = 8'h01,
    RC_SEND_LAST    = 8'h02,
    RC_SEND_ONLY    = 8'h04,
    RC_WRITE_FIRST  = 8'h06,
    RC_WRITE_MIDDLE = 8'h07,
    RC_WRITE_LAST   = 8'h08,
    RC_WRITE_ONLY   = 8'h0A,
    RC_READ_REQUEST = 8'h0C
  } rc_op_e;

  ////////////////////
  // structs
  ////////////////////

  typedef struct packed {
    logic [QPN_W-1:0]  qp_idx;
    logic [IDX_W-1:0]  sq_prod_idx;
    logic [IDX_W-1:0]  cq_head_idx;
    logic [ADDR_W-1:0] sq_base_addr;
  } sq_db_t;

  typedef struct packed {
    logic [287:0]      rsvd_top;
    logic [ADDR_W-1:0] remote_vaddr;  // 223..160
    logic [23:0]       rsvd_mid;
    wqe_op_e           opcode;        // 135..128
    logic [LEN_W-1:0]  length;
    logic [ADDR_W-1:0] local_addr;
    logic [15:0]       rsvd_low;
    logic [15:0]       wr_id;
  } wqe_t;

  typedef struct packed {
    rc_op_e            opcode;
    logic [QPN_W-1:0]  qpn;
    logic              last;
    logic [ADDR_W-1:0] remote_vaddr;
    logic [ADDR_W-1:0] local_addr;
    logic [LEN_W-1:0]  len;
  } sq_req_t;

  typedef struct packed {
    logic [QPN_W-1:0] qp_idx;
    logic [IDX_W-1:0] head_idx;
  } cq_head_t;

endpackage
